/* sim/xdatapath_golden.txt */
# sela0 selb0 fn0 sela1 selb1 fn1 in_a in_b result0 result1, all hex
# fn: 0 add 1 sub 2 cmp_sig 3 cmp_uns 4 or 5 and 6 xor 7 sext8 8 sext16 9 sra a srl b mux c clz d max e min f abs
0 1 0 1 0 1 12345678 11111111 23456789 01234567
0 1 0 7 7 1 ffffffff 00000002 00000001 01234567
0 1 1 7 7 1 00000005 00000003 fffffffe 01234567
0 1 1 7 7 1 00000003 00000010 0000000d 01234567
0 1 f 7 7 1 fffffff6 12345678 0000000a 01234567
0 1 f 7 7 1 00000007 00000000 00000007 01234567
0 1 f 7 7 1 80000000 00000000 80000000 01234567
0 1 4 7 7 1 f0f00000 0000ff0f f0f0ff0f 01234567
0 1 5 7 7 1 ff00ff00 0ff00ff0 0f000f00 01234567
0 1 6 7 7 1 aaaa5555 ffff0000 55555555 01234567
0 1 7 7 7 1 12345680 00000000 ffffff80 01234567
0 1 8 7 7 1 abcd8001 00000000 ffff8001 01234567
0 1 9 7 7 1 80000010 00000000 c0000008 01234567
0 1 a 7 7 1 80000010 00000000 40000008 01234567
0 1 c 7 7 1 00010000 00000000 0000000f 01234567
0 1 c 7 7 1 00000000 00000000 00000020 01234567
0 1 2 0 1 3 00000001 ffffffff fffffffe 7ffffffe
0 1 2 0 1 3 80000000 7fffffff 7fffffff ffffffff
0 1 2 0 1 3 12345678 12345678 00000000 00000000
0 1 d 0 1 e fffffff0 00000005 00000005 fffffff0
0 1 d 0 1 e 7fffffff 80000000 7fffffff 80000000
0 1 0 2 0 1 00000010 00000020 00000030 ffffffe0
0 1 6 2 1 c 0000ffff 00ff00ff 00ffff00 00000008
0 1 a 6 4 0 00000100 00000000 00000080 00000180
0 1 b 1 0 b 7fffffff cafef00d cafef00d 00000000
0 1 b 1 0 b 80000000 12345678 00000000 80000000
0 1 0 7 0 b 00000001 00000002 00000003 80000000
7 1 0 1 0 b 11111111 00000005 00000003 11111111
0 1 1 1 7 b 00000001 00000000 ffffffff 11111111

/* verilog.f */
+incdir+hdl
hdl/xalu_pkg.sv
hdl/xinmux.sv
hdl/xalu_decode.sv
hdl/xalu_exec.sv
hdl/xalu_result.sv
hdl/xalu.sv
hdl/xdatapath.sv
sim/xdatapath_assertions.sv
sim/xdatapath_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module xdatapath_tb \
	-Mdir obj_dir -o xdatapath_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/xdatapath_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation run returned status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* sim/xdatapath_tb.sv */
`timescale 1ns/100ps
`include "xdefs_params.svh"

module xdatapath_tb;

	import xalu_pkg::*;

	localparam int DONE_TIMEOUT = 20;

	logic                           clk;
	logic                           rst_reg;
	logic                           conf_valid;
	alu_conf_t [`N_ALU-1:0]         conf;
	logic                           in_valid;
	logic [`DATA_W-1:0]             in_a;
	logic [`DATA_W-1:0]             in_b;
	logic [`N_ALU-1:0][`DATA_W-1:0] result;
	logic                           done;

	int                 fd;
	int                 n_fields;
	int                 n_vec;
	string              line;
	// sela0 selb0 fn0 sela1 selb1 fn1 in_a in_b result0 result1
	logic [`DATA_W-1:0] field [10];

	xdatapath u_xdatapath (
		.clk        (clk),
		.rst_reg    (rst_reg),
		.conf_valid (conf_valid),
		.conf       (conf),
		.in_valid   (in_valid),
		.in_a       (in_a),
		.in_b       (in_b),
		.result     (result),
		.done       (done)
	);

	bind xdatapath xdatapath_assertions u_assertions (
		.clk      (clk),
		.rst_reg  (rst_reg),
		.in_valid (in_valid),
		.done     (done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Bound checker failures end the run at once
	always @(negedge clk) begin
		if (u_xdatapath.u_assertions.n_fail != 0) begin
			stop_with_error("A bound assertion on done failed");
		end
	end

	task automatic check_word(
		input string              name,
		input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp
	);
		if (got !== exp) begin
			stop_with_error($sformatf("Fail at %t: %s is %h, expected %h",
				$realtime, name, got, exp));
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("Fail at %t: %s is %b, expected %b",
				$realtime, name, got, exp));
		end
	endtask

	function automatic alu_conf_t make_conf(
		input logic [`DATA_W-1:0] sel_a,
		input logic [`DATA_W-1:0] sel_b,
		input logic [`DATA_W-1:0] fn
	);
		alu_conf_t c;
		c.sela = sel_a[`N_W-1:0];
		c.selb = sel_b[`N_W-1:0];
		c.fns = alu_fn_t'(fn[3:0]);
		return c;
	endfunction

	task automatic wait_for_done();
		int waited;
		waited = 0;
		while (done !== 1'b1) begin
			if (waited == DONE_TIMEOUT) begin
				stop_with_error("Timeout: done never came after in_valid");
			end else begin
				@(posedge clk);
				#1;
				waited++;
			end
		end
	endtask

	// Config strobe, input strobe one cycle later, then wait for done
	task automatic run_vector(
		input alu_conf_t          conf0,
		input alu_conf_t          conf1,
		input logic [`DATA_W-1:0] a,
		input logic [`DATA_W-1:0] b,
		input logic [`DATA_W-1:0] exp0,
		input logic [`DATA_W-1:0] exp1
	);
		@(posedge clk);
		#1;
		conf_valid = 1'b1;
		conf[0] = conf0;
		conf[1] = conf1;
		check_strobe("done", done, 1'b0);
		@(posedge clk);
		#1;
		conf_valid = 1'b0;
		in_valid = 1'b1;
		in_a = a;
		in_b = b;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		wait_for_done();
		check_word("result[0]", result[0], exp0);
		check_word("result[1]", result[1], exp1);
		@(posedge clk);
		#1;
		check_strobe("done", done, 1'b0);
	endtask

	initial begin
		$timeformat(-9, 1, " ns", 0);
		rst_reg = 1'b1;
		conf_valid = 1'b0;
		conf = '0;
		in_valid = 1'b0;
		in_a = '0;
		in_b = '0;
		n_vec = 0;
		fd = $fopen("sim/xdatapath_golden.txt", "r");
		if (fd == 0) begin
			stop_with_error("Cannot open golden file sim/xdatapath_golden.txt");
		end
		repeat (5) @(posedge clk);
		#1;
		rst_reg = 1'b0;
		check_word("result[0]", result[0], '0);
		check_word("result[1]", result[1], '0);
		check_strobe("done", done, 1'b0);

		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
					field[0], field[1], field[2], field[3], field[4],
					field[5], field[6], field[7], field[8], field[9]);
				if (n_fields != 10) begin
					stop_with_error("Golden file line does not hold ten fields");
				end
				run_vector(make_conf(field[0], field[1], field[2]),
					make_conf(field[3], field[4], field[5]),
					field[6], field[7], field[8], field[9]);
				n_vec++;
			end
		end
		$fclose(fd);

		if (n_vec == 0) begin
			stop_with_error("Golden file holds no vectors");
		end else if (u_xdatapath.u_assertions.n_fail != 0) begin
			stop_with_error("A bound assertion on done failed");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

/* sim/xdatapath_assertions.sv */
`timescale 1ns/100ps

module xdatapath_assertions (
	input logic clk,
	input logic rst_reg,
	input logic in_valid,
	input logic done
);

	int unsigned n_fail = 0;

	// Quiet in reset and for five cycles after release
	a_reset_quiet: assert property (@(posedge clk)
		$past(rst_reg) || $past(rst_reg, 2) || $past(rst_reg, 3) ||
		$past(rst_reg, 4) || $past(rst_reg, 5) || $past(rst_reg, 6) |-> !done)
		else begin
			n_fail++;
			$error("done high during reset or within five cycles after it");
		end

	a_done_single: assert property (@(posedge clk) disable iff (rst_reg)
		done |=> !done)
		else begin
			n_fail++;
			$error("done held for more than one cycle");
		end

	// done is seen one edge after the stage that sets it
	a_done_latency: assert property (@(posedge clk) disable iff (rst_reg)
		done == $past(in_valid, 6))
		else begin
			n_fail++;
			$error("done does not follow in_valid by five cycles");
		end

endmodule

/* hdl/xdatapath.sv */
`timescale 1ns/100ps
`include "xdefs_params.svh"

module xdatapath (
	input  logic                                clk,
	input  logic                                rst_reg,
	input  logic                                conf_valid,
	input  xalu_pkg::alu_conf_t [`N_ALU-1:0]    conf,
	input  logic                                in_valid,
	input  logic [`DATA_W-1:0]                  in_a,
	input  logic [`DATA_W-1:0]                  in_b,
	output logic [`N_ALU-1:0][`DATA_W-1:0]      result,
	output logic                                done
);

	import xalu_pkg::*;

	// Both selects at no source, cell disabled
	localparam alu_conf_t CONF_OFF = '{sela: '1, selb: '1, fns: ADD};

	alu_conf_t [`N_ALU-1:0]     conf_reg;
	logic [`DATA_W-1:0]         in_a_reg;
	logic [`DATA_W-1:0]         in_b_reg;
	logic                       in_strobe;
	logic [4:0]                 done_sr;
	logic [`N-1:0][`DATA_W-1:0] bus;
	logic [`N-1:0][`DATA_W-1:0] bus_prev;

	always_ff @(posedge clk) begin
		if (rst_reg) begin
			for (int i = 0; i < `N_ALU; i++) begin
				conf_reg[i] <= CONF_OFF;
			end
		end else if (conf_valid) begin
			conf_reg <= conf;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_reg) begin
			in_a_reg <= '0;
			in_b_reg <= '0;
		end else if (in_valid) begin
			in_a_reg <= in_a;
			in_b_reg <= in_b;
		end
	end

	// Strobe rides with the input entries, then five more stages to done
	always_ff @(posedge clk) begin
		if (rst_reg) begin
			in_strobe <= 1'b0;
			done_sr <= '0;
		end else begin
			in_strobe <= in_valid;
			done_sr <= {done_sr[3:0], in_strobe};
		end
	end

	assign done = done_sr[4];

	assign bus[0] = in_a_reg;
	assign bus[1] = in_b_reg;

	always_ff @(posedge clk) begin
		if (rst_reg) begin
			bus_prev <= '0;
		end else begin
			bus_prev <= bus;
		end
	end

	for (genvar g = 0; g < `N_ALU; g++) begin : g_alu
		xalu u_xalu (
			.clk      (clk),
			.rst_reg  (rst_reg),
			.bus      (bus),
			.bus_prev (bus_prev),
			.conf     (conf_reg[g]),
			.result   (result[g])
		);

		assign bus[2 + g] = result[g];
	end

endmodule

/* hdl/xalu.sv */
`timescale 1ns/100ps
`include "xdefs_params.svh"

module xalu (
	input  logic                       clk,
	input  logic                       rst_reg,
	input  logic [`N-1:0][`DATA_W-1:0] bus,
	input  logic [`N-1:0][`DATA_W-1:0] bus_prev,
	input  xalu_pkg::alu_conf_t        conf,
	output logic [`DATA_W-1:0]         result
);

	import xalu_pkg::*;

	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] op_a_reg;
	logic [`DATA_W-1:0] op_b_reg;
	logic [`DATA_W:0]   sum;
	logic               enable_a;
	logic               enable_b;
	logic               enabled;
	alu_fn_t            fns_reg;
	adder_ctrl_t        ctrl;

	xinmux u_mux_a (
		.sel      (conf.sela),
		.bus      (bus),
		.bus_prev (bus_prev),
		.data_out (op_a),
		.enabled  (enable_a)
	);

	xinmux u_mux_b (
		.sel      (conf.selb),
		.bus      (bus),
		.bus_prev (bus_prev),
		.data_out (op_b),
		.enabled  (enable_b)
	);

	// Enable and function line up with the operand registers
	always_ff @(posedge clk) begin
		if (rst_reg) begin
			enabled <= 1'b0;
			fns_reg <= ADD;
		end else begin
			enabled <= enable_a & enable_b;
			fns_reg <= conf.fns;
		end
	end

	xalu_decode u_decode (
		.fns  (conf.fns),
		.ctrl (ctrl)
	);

	xalu_exec u_exec (
		.clk      (clk),
		.rst_reg  (rst_reg),
		.op_a     (op_a),
		.op_b     (op_b),
		.ctrl     (ctrl),
		.op_a_reg (op_a_reg),
		.op_b_reg (op_b_reg),
		.sum      (sum)
	);

	xalu_result u_result (
		.clk      (clk),
		.rst_reg  (rst_reg),
		.fns      (fns_reg),
		.enabled  (enabled),
		.op_a_reg (op_a_reg),
		.op_b_reg (op_b_reg),
		.sum      (sum),
		.result   (result)
	);

endmodule

/* hdl/xalu_result.sv */
`timescale 1ns/100ps
`include "xdefs_params.svh"

module xalu_result (
	input  logic               clk,
	input  logic               rst_reg,
	input  xalu_pkg::alu_fn_t  fns,
	input  logic               enabled,
	input  logic [`DATA_W-1:0] op_a_reg,
	input  logic [`DATA_W-1:0] op_b_reg,
	input  logic [`DATA_W:0]   sum,
	output logic [`DATA_W-1:0] result
);

	import xalu_pkg::*;

	localparam int CLZ_W = $clog2(`DATA_W + 1);

	logic [CLZ_W-1:0]   clz;
	logic [`DATA_W-1:0] result_int;

	// Leading zeros of a, all zero gives DATA_W
	always_comb begin
		clz = CLZ_W'(`DATA_W);
		for (int i = 0; i < `DATA_W; i++) begin
			if (op_a_reg[i]) begin
				clz = CLZ_W'(`DATA_W - 1 - i);
			end
		end
	end

	always_comb begin
		result_int = sum[`DATA_W-1:0];
		case (fns)
			OR:        result_int = op_a_reg | op_b_reg;
			AND:       result_int = op_a_reg & op_b_reg;
			XOR:       result_int = op_a_reg ^ op_b_reg;
			SEXT8:     result_int = {{(`DATA_W-8){op_a_reg[7]}}, op_a_reg[7:0]};
			SEXT16:    result_int = {{(`DATA_W-16){op_a_reg[15]}}, op_a_reg[15:0]};
			SHR_ARITH: result_int = {op_a_reg[`DATA_W-1], op_a_reg[`DATA_W-1:1]};
			SHR_LOG:   result_int = {1'b0, op_a_reg[`DATA_W-1:1]};
			MUX:       result_int = op_a_reg[`DATA_W-1] ? '0 : op_b_reg;
			CLZ:       result_int = {{(`DATA_W-CLZ_W){1'b0}}, clz};
			CMP_SIG,
			CMP_UNS:   result_int = {sum[`DATA_W], sum[`DATA_W-2:0]};
			// Sum is b - a, so a clear top bit means b >= a
			MAX:       result_int = sum[`DATA_W] ? op_a_reg : op_b_reg;
			MIN:       result_int = sum[`DATA_W] ? op_b_reg : op_a_reg;
			default:   result_int = sum[`DATA_W-1:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_reg) begin
			result <= '0;
		end else if (enabled) begin
			result <= result_int;
		end
	end

endmodule

/* hdl/xalu_exec.sv */
`timescale 1ns/100ps
`include "xdefs_params.svh"

module xalu_exec (
	input  logic                  clk,
	input  logic                  rst_reg,
	input  logic [`DATA_W-1:0]    op_a,
	input  logic [`DATA_W-1:0]    op_b,
	input  xalu_pkg::adder_ctrl_t ctrl,
	output logic [`DATA_W-1:0]    op_a_reg,
	output logic [`DATA_W-1:0]    op_b_reg,
	output logic [`DATA_W:0]      sum
);

	import xalu_pkg::*;

	adder_ctrl_t      ctrl_reg;
	logic             a_msb;
	logic             b_msb;
	logic             inv;
	logic             carry;
	logic [`DATA_W:0] a_ext;
	logic [`DATA_W:0] b_ext;

	// Controls travel with their operands
	always_ff @(posedge clk) begin
		if (rst_reg) begin
			op_a_reg <= '0;
			op_b_reg <= '0;
			ctrl_reg <= '0;
		end else begin
			op_a_reg <= op_a;
			op_b_reg <= op_b;
			ctrl_reg <= ctrl;
		end
	end

	assign a_msb = ctrl_reg.sign_ext & op_a_reg[`DATA_W-1];
	assign b_msb = ctrl_reg.sign_ext & op_b_reg[`DATA_W-1];

	// ABS negates a only when a is negative
	assign inv = ctrl_reg.abs_sel ? op_a_reg[`DATA_W-1] : ctrl_reg.inv_a;
	assign carry = ctrl_reg.abs_sel ? op_a_reg[`DATA_W-1] : ctrl_reg.cin;

	assign a_ext = {a_msb, op_a_reg} ^ {(`DATA_W+1){inv}};
	assign b_ext = ctrl_reg.zero_b ? '0 : {b_msb, op_b_reg};
	assign sum = a_ext + b_ext + {{`DATA_W{1'b0}}, carry};

endmodule

/* hdl/xalu_decode.sv */
`timescale 1ns/100ps

module xalu_decode (
	input  xalu_pkg::alu_fn_t     fns,
	output xalu_pkg::adder_ctrl_t ctrl
);

	import xalu_pkg::*;

	// Default is a plain a + b
	always_comb begin
		ctrl = '0;
		case (fns)
			SUB,
			CMP_UNS: begin
				ctrl.inv_a = 1'b1;
				ctrl.cin = 1'b1;
			end
			CMP_SIG,
			MAX,
			MIN: begin
				ctrl.inv_a = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.sign_ext = 1'b1;
			end
			ABS: begin
				// Inversion decided later from the sign of a
				ctrl.zero_b = 1'b1;
				ctrl.abs_sel = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

/* hdl/xinmux.sv */
`timescale 1ns/100ps
`include "xdefs_params.svh"

module xinmux (
	input  logic [`N_W-1:0]            sel,
	input  logic [`N-1:0][`DATA_W-1:0] bus,
	input  logic [`N-1:0][`DATA_W-1:0] bus_prev,
	output logic [`DATA_W-1:0]         data_out,
	output logic                       enabled
);

	localparam logic [`N_W-1:0] SEL_NONE = '1;

	// Low codes read the current bus, high codes the previous one
	always_comb begin
		data_out = '0;
		enabled = 1'b1;
		if (sel == SEL_NONE) begin
			enabled = 1'b0;
		end else if (sel < `N_W'(`N)) begin
			data_out = bus[sel[`N_W-2:0]];
		end else begin
			data_out = bus_prev[sel[`N_W-2:0]];
		end
	end

endmodule

/* hdl/xalu_pkg.sv */
`include "xdefs_params.svh"

package xalu_pkg;

	// ALU function codes
	typedef enum logic [3:0] {
		ADD,
		SUB,
		CMP_SIG,
		CMP_UNS,
		OR,
		AND,
		XOR,
		SEXT8,
		SEXT16,
		SHR_ARITH,
		SHR_LOG,
		MUX,
		CLZ,
		MAX,
		MIN,
		ABS
	} alu_fn_t;

	// Per-cell configuration word
	typedef struct packed {
		logic [`N_W-1:0] sela;
		logic [`N_W-1:0] selb;
		alu_fn_t         fns;
	} alu_conf_t;

	// Controls for the shared 33-bit adder
	typedef struct packed {
		logic inv_a;
		logic zero_b;
		logic cin;
		logic sign_ext;
		logic abs_sel;
	} adder_ctrl_t;

endpackage

/* hdl/xdefs_params.svh */
`ifndef XDEFS_PARAMS_SVH
`define XDEFS_PARAMS_SVH

// Datapath word width
`define DATA_W 32

// Bus entries: two external inputs, then one per ALU cell
`define N 4

// Operand select width, code 7 means no source
`define N_W 3

`define N_ALU 2

`endif
